// ==== all.f ====
common/hitMapPkg.sv
common/hitCtrlPkg.sv
common/memPortIf.sv
common/readTagIf.sv
verilog/rowMemory.sv
verilog/hitMapController.sv
readPipeline/readPipeline.sv
writeMerger/writeMerger.sv
verilog/hitMapTop.sv
tests/hitMapTb.sv

// ==== tests/hitMapTb.sv ====
`timescale 1ns/1ps

module hitMapTb import hitMapPkg::*, hitCtrlPkg::*; ();

    localparam int ReadLatency  = 2;               // same values as the DUT defaults
    localparam int SettleCycles = 4;
    localparam int ClkPeriod    = 20;
    localparam int ResetCycles  = 4;
    localparam int DrainCycles  = 2 * (ReadLatency + 2); // hit set fully written back
    localparam int ReadyTimeout = 4 * (NumRows + SettleCycles);
    localparam int DrainTimeout = 64;
    localparam int Rounds       = 8;
    localparam int BurstWrites  = 12;
    localparam int BurstReads   = 16;

    // one outstanding read and what it must return
    typedef struct packed {
        readKindT    kind;
        rowIndexT    row;
        colIndexT    col;
        rowBitsT     value;                        // bit result sits in value[0]
        logic [31:0] due;                          // counter value when the strobe is seen
    } expectT;

    logic     clk = 1'b0;
    logic     reset;
    logic     write;
    ssidT     writeSsid;
    logic     read;
    ssidT     readSsid;
    logic     readRow;
    rowIndexT readRowIndex;
    logic     ready;
    logic     bitValid;
    ssidT     bitSsid;
    logic     bitValue;
    logic     rowValid;
    rowIndexT rowIndex;
    rowBitsT  rowBits;

    rowBitsT     shadow [NumRows];                 // reference copy of the hit map
    expectT      expectQ [$];
    expectT      head;
    logic [31:0] cycleCount = 0;
    int          seed = 72793;
    int          valueErrors = 0;
    int          protocolErrors = 0;
    int          timeoutErrors = 0;

    hitMapTop #(
        .ReadLatency  (ReadLatency),
        .SettleCycles (SettleCycles)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .write        (write),
        .writeSsid    (writeSsid),
        .read         (read),
        .readSsid     (readSsid),
        .readRow      (readRow),
        .readRowIndex (readRowIndex),
        .ready        (ready),
        .bitValid     (bitValid),
        .bitSsid      (bitSsid),
        .bitValue     (bitValue),
        .rowValid     (rowValid),
        .rowIndex     (rowIndex),
        .rowBits      (rowBits)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;              // edges seen so far
    end

    // expected bit or row for a read taken from the shadow map
    function automatic rowBitsT referenceRead(readKindT kind, rowIndexT row, colIndexT col);
        if (kind == kindRow) begin
            return shadow[row];
        end
        return rowBitsT'(shadow[row][col]);
    endfunction

    // every strobe pops the oldest outstanding read
    always @(posedge clk) begin
        if (bitValid === 1'b1 || rowValid === 1'b1) begin
            assert (expectQ.size() > 0) else begin
                protocolErrors++;
                $display("result strobe at %0t while no read was outstanding", $time);
            end
            if (expectQ.size() > 0) begin
                head = expectQ.pop_front();
                assert (cycleCount == head.due) else begin
                    valueErrors++;
                    $display("CHECK FAILED at %0t: result seen at cycle %0d, expected %0d",
                             $time, cycleCount, head.due);
                end
                assert (bitValid === (head.kind == kindBit)) else begin
                    protocolErrors++;
                    $display("result at %0t has the wrong kind for row %0d", $time, head.row);
                end
                if (bitValid === 1'b1) begin
                    assert (bitSsid === {head.row, head.col} && bitValue === head.value[0])
                    else begin
                        valueErrors++;
                        $display("CHECK FAILED at %0t: bit %h = %b, expected %h = %b", $time,
                                 bitSsid, bitValue, {head.row, head.col}, head.value[0]);
                    end
                end else begin
                    assert (rowIndex === head.row && rowBits === head.value) else begin
                        valueErrors++;
                        $display("CHECK FAILED at %0t: row %0d = %h, expected row %0d = %h",
                                 $time, rowIndex, rowBits, head.row, head.value);
                    end
                end
            end
        end
    end

    // drives one request cycle and models write > read > readRow priority
    task automatic driveRequest(input logic doWrite, input ssidT wSsid, input logic doRead,
                                input ssidT rSsid, input logic doRow, input rowIndexT rIdx);
        expectT   entry;
        rowIndexT r;
        colIndexT c;
        @(posedge clk);
        write        <= doWrite;
        writeSsid    <= wSsid;
        read         <= doRead;
        readSsid     <= rSsid;
        readRow      <= doRow;
        readRowIndex <= rIdx;
        entry.due = cycleCount + ReadLatency + 3;  // sampled at the next edge and seen one late
        if (doWrite) begin
            {r, c} = wSsid;
            shadow[r][c] = 1'b1;                   // lower priority requests are dropped
        end else if (doRead) begin
            entry.kind = kindBit;
            {entry.row, entry.col} = rSsid;
            entry.value = referenceRead(kindBit, entry.row, entry.col);
            expectQ.push_back(entry);
        end else if (doRow) begin
            entry.kind  = kindRow;
            entry.row   = rIdx;
            entry.col   = '0;
            entry.value = referenceRead(kindRow, rIdx, '0);
            expectQ.push_back(entry);
        end
    endtask

    task automatic issueWrite(input ssidT s);
        driveRequest(1'b1, s, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic issueBitRead(input ssidT s);
        driveRequest(1'b0, '0, 1'b1, s, 1'b0, '0);
    endtask

    task automatic issueRowRead(input rowIndexT r);
        driveRequest(1'b0, '0, 1'b0, '0, 1'b1, r);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            write   <= 1'b0;
            read    <= 1'b0;
            readRow <= 1'b0;
        end
    endtask

    task automatic reportAndFinish();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // reads in flight are lost and the map comes back all zero
    task automatic applyReset();
        reset   <= 1'b1;
        write   <= 1'b0;
        read    <= 1'b0;
        readRow <= 1'b0;
        expectQ.delete();
        for (int i = 0; i < NumRows; i++) begin
            shadow[i] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (ready !== 1'b1 && waited < ReadyTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (ready !== 1'b1) begin
            timeoutErrors++;
            $display("timeout: ready did not rise within %0d cycles", ReadyTimeout);
            reportAndFinish();
        end
    endtask

    task automatic waitDrain();
        int waited;
        idle(1);
        waited = 0;
        while (expectQ.size() != 0 && waited < DrainTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (expectQ.size() != 0) begin
            timeoutErrors++;
            $display("timeout: %0d read results never arrived", expectQ.size());
        end
    endtask

    task automatic readAllRows();
        for (int i = 0; i < NumRows; i++) begin
            issueRowRead(rowIndexT'(i));
        end
        waitDrain();
    endtask

    initial begin
        reset        = 1'b1;
        write        = 1'b0;
        writeSsid    = '0;
        read         = 1'b0;
        readSsid     = '0;
        readRow      = 1'b0;
        readRowIndex = '0;

        // clear after reset
        applyReset();
        waitReady();
        readAllRows();

        // single hit and its neighbour
        issueWrite({rowIndexT'(11), colIndexT'(6)});
        idle(DrainCycles);
        issueBitRead({rowIndexT'(11), colIndexT'(6)});
        issueBitRead({rowIndexT'(11), colIndexT'(7)});
        issueRowRead(rowIndexT'(11));
        waitDrain();

        // back to back hits in one row then two rows interleaved
        issueWrite({rowIndexT'(5), colIndexT'(0)});
        issueWrite({rowIndexT'(5), colIndexT'(3)});
        issueWrite({rowIndexT'(5), colIndexT'(7)});
        issueWrite({rowIndexT'(5), colIndexT'(12)});
        issueWrite({rowIndexT'(5), colIndexT'(1)});
        issueWrite({rowIndexT'(9), colIndexT'(2)});
        issueWrite({rowIndexT'(5), colIndexT'(15)});
        issueWrite({rowIndexT'(9), colIndexT'(8)});
        issueWrite({rowIndexT'(9), colIndexT'(9)});
        issueWrite({rowIndexT'(9), colIndexT'(2)});   // same bit twice
        idle(DrainCycles);
        issueRowRead(rowIndexT'(5));
        issueRowRead(rowIndexT'(9));
        waitDrain();

        // random write bursts followed by mixed reads
        for (int round = 0; round < Rounds; round++) begin
            for (int i = 0; i < BurstWrites; i++) begin
                issueWrite(ssidT'($random(seed)));
            end
            idle(DrainCycles);
            for (int i = 0; i < BurstReads; i++) begin
                if ($random(seed) & 1) begin
                    issueBitRead(ssidT'($random(seed)));
                end else begin
                    issueRowRead(rowIndexT'($random(seed)));
                end
            end
            waitDrain();
        end

        // write beats read and read beats readRow
        issueBitRead({rowIndexT'(20), colIndexT'(4)});
        driveRequest(1'b1, {rowIndexT'(20), colIndexT'(4)}, 1'b1,
                     {rowIndexT'(21), colIndexT'(0)}, 1'b0, '0);
        driveRequest(1'b0, '0, 1'b1, {rowIndexT'(5), colIndexT'(3)}, 1'b1, rowIndexT'(9));
        idle(DrainCycles);
        issueRowRead(rowIndexT'(20));
        waitDrain();

        // reset with reads still in the pipeline
        issueRowRead(rowIndexT'(5));
        issueBitRead({rowIndexT'(9), colIndexT'(8)});
        issueRowRead(rowIndexT'(20));
        idle(1);
        applyReset();
        waitReady();
        readAllRows();

        idle(DrainCycles);
        assert (expectQ.size() == 0) else begin
            protocolErrors++;
            $display("%0d reads still outstanding at the end of the run", expectQ.size());
        end
        reportAndFinish();
    end

endmodule

// ==== verilog/hitMapTop.sv ====
`timescale 1ns/1ps

module hitMapTop import hitMapPkg::*; #(
    parameter int ReadLatency  = 2,                // memory read latency in cycles
    parameter int SettleCycles = 4                 // wait after the clear sweep
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     write,
    input  ssidT     writeSsid,
    input  logic     read,
    input  ssidT     readSsid,
    input  logic     readRow,
    input  rowIndexT readRowIndex,
    output logic     ready,
    output logic     bitValid,
    output ssidT     bitSsid,
    output logic     bitValue,
    output logic     rowValid,
    output rowIndexT rowIndex,
    output rowBitsT  rowBits
);

    logic     returnValid;                         // pipeline to merger
    rowIndexT returnRow;
    colIndexT returnCol;
    rowBitsT  returnData;

    logic     mergeValid;                          // merger to controller
    rowIndexT mergeRow;
    rowBitsT  mergeData;

    memPortIf memBus ();
    readTagIf tagBus ();

    rowMemory #(
        .ReadLatency (ReadLatency)
    ) memory (
        .clk  (clk),
        .port (memBus)
    );

    hitMapController #(
        .SettleCycles (SettleCycles)
    ) controller (
        .clk          (clk),
        .reset        (reset),
        .write        (write),
        .writeSsid    (writeSsid),
        .read         (read),
        .readSsid     (readSsid),
        .readRow      (readRow),
        .readRowIndex (readRowIndex),
        .mergeValid   (mergeValid),
        .mergeRow     (mergeRow),
        .mergeData    (mergeData),
        .ready        (ready),
        .memPort      (memBus),
        .tag          (tagBus)
    );

    readPipeline #(
        .ReadLatency (ReadLatency)
    ) pipeline (
        .clk         (clk),
        .reset       (reset),
        .tag         (tagBus),
        .memPort     (memBus),
        .bitValid    (bitValid),
        .bitSsid     (bitSsid),
        .bitValue    (bitValue),
        .rowValid    (rowValid),
        .rowIndex    (rowIndex),
        .rowBits     (rowBits),
        .returnValid (returnValid),
        .returnRow   (returnRow),
        .returnCol   (returnCol),
        .returnData  (returnData)
    );

    writeMerger #(
        .ReadLatency (ReadLatency)
    ) merger (
        .clk         (clk),
        .reset       (reset),
        .returnValid (returnValid),
        .returnRow   (returnRow),
        .returnCol   (returnCol),
        .returnData  (returnData),
        .mergeValid  (mergeValid),
        .mergeRow    (mergeRow),
        .mergeData   (mergeData)
    );

endmodule

// ==== writeMerger/writeMerger.sv ====
`timescale 1ns/1ps

module writeMerger import hitMapPkg::*; #(
    parameter int ReadLatency = 2                  // sets how many write-backs can be in flight
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     returnValid,                  // row read for a hit set is back
    input  rowIndexT returnRow,
    input  colIndexT returnCol,
    input  rowBitsT  returnData,
    output logic     mergeValid,                   // write-back strobe to the controller
    output rowIndexT mergeRow,
    output rowBitsT  mergeData
);

    // write-backs not yet seen by a read returning now
    localparam int Depth = ReadLatency + 1;

    logic     histValid [Depth];                   // index 0 is the newest
    rowIndexT histRow [Depth];
    rowBitsT  histData [Depth];

    rowBitsT baseRow;
    rowBitsT mergedRow;

    // pick newest pending copy of the row, memory data may be stale
    always_comb begin
        baseRow = returnData;
        for (int i = Depth - 1; i >= 0; i--) begin
            if (histValid[i] && (histRow[i] == returnRow)) begin
                baseRow = histData[i];             // later index overrides older entries
            end
        end
        mergedRow = baseRow | (rowBitsT'(1) << returnCol); // set the new hit
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mergeValid <= 1'b0;
            for (int i = 0; i < Depth; i++) begin
                histValid[i] <= 1'b0;
            end
        end else begin
            mergeValid <= returnValid;
            if (returnValid) begin
                histValid[0] <= 1'b1;
                for (int i = 1; i < Depth; i++) begin
                    histValid[i] <= histValid[i-1];
                end
            end
        end
    end

    // history only advances on a write-back
    always_ff @(posedge clk) begin
        if (returnValid) begin
            mergeRow    <= returnRow;
            mergeData   <= mergedRow;
            histRow[0]  <= returnRow;
            histData[0] <= mergedRow;
            for (int i = 1; i < Depth; i++) begin
                histRow[i]  <= histRow[i-1];
                histData[i] <= histData[i-1];
            end
        end
    end

endmodule

// ==== readPipeline/readPipeline.sv ====
`timescale 1ns/1ps

module readPipeline import hitMapPkg::*, hitCtrlPkg::*; #(
    parameter int ReadLatency = 2                  // memory data stages to match
) (
    input  logic     clk,
    input  logic     reset,
    readTagIf.sink   tag,
    memPortIf.sink   memPort,
    output logic     bitValid,                     // one-cycle strobe per bit read
    output ssidT     bitSsid,
    output logic     bitValue,
    output logic     rowValid,                     // one-cycle strobe per row read
    output rowIndexT rowIndex,
    output rowBitsT  rowBits,
    output logic     returnValid,                  // raw row for the merger, not registered
    output rowIndexT returnRow,
    output colIndexT returnCol,
    output rowBitsT  returnData
);

    localparam int Last = ReadLatency - 1;         // stage aligned with readData

    logic     stageValid [ReadLatency];
    readKindT stageKind [ReadLatency];
    rowIndexT stageRow [ReadLatency];
    colIndexT stageCol [ReadLatency];

    logic doneBit;
    logic doneRow;

    // valid bits, dropped on reset so in-flight reads vanish
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ReadLatency; i++) begin
                stageValid[i] <= 1'b0;
            end
        end else begin
            stageValid[0] <= tag.push;
            for (int i = 1; i < ReadLatency; i++) begin
                stageValid[i] <= stageValid[i-1];
            end
        end
    end

    // tag payload moves in step with the memory data chain
    always_ff @(posedge clk) begin
        stageKind[0] <= tag.kind;
        stageRow[0]  <= tag.row;
        stageCol[0]  <= tag.col;
        for (int i = 1; i < ReadLatency; i++) begin
            stageKind[i] <= stageKind[i-1];
            stageRow[i]  <= stageRow[i-1];
            stageCol[i]  <= stageCol[i-1];
        end
    end

    assign doneBit = stageValid[Last] && (stageKind[Last] == kindBit);
    assign doneRow = stageValid[Last] && (stageKind[Last] == kindRow);

    always_ff @(posedge clk) begin
        if (reset) begin
            bitValid <= 1'b0;
            rowValid <= 1'b0;
        end else begin
            bitValid <= doneBit;
            rowValid <= doneRow;
        end
    end

    // result payload, held between strobes
    always_ff @(posedge clk) begin
        if (doneBit) begin
            bitSsid  <= {stageRow[Last], stageCol[Last]}; // rebuild the SSID
            bitValue <= memPort.readData[stageCol[Last]];
        end
        if (doneRow) begin
            rowIndex <= stageRow[Last];
            rowBits  <= memPort.readData;
        end
    end

    // merge reads go straight on, the merger registers them
    assign returnValid = stageValid[Last] && (stageKind[Last] == kindMerge);
    assign returnRow   = stageRow[Last];
    assign returnCol   = stageCol[Last];
    assign returnData  = memPort.readData;

endmodule

// ==== verilog/hitMapController.sv ====
`timescale 1ns/1ps

module hitMapController import hitMapPkg::*, hitCtrlPkg::*; #(
    parameter int SettleCycles = 4                 // idle cycles between sweep end and ready
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     write,                        // set the hit bit of writeSsid
    input  ssidT     writeSsid,
    input  logic     read,                         // look up one bit
    input  ssidT     readSsid,
    input  logic     readRow,                      // dump a whole row
    input  rowIndexT readRowIndex,
    input  logic     mergeValid,                   // merged row ready for write back
    input  rowIndexT mergeRow,
    input  rowBitsT  mergeData,
    output logic     ready,
    memPortIf.ctrl   memPort,
    readTagIf.source tag
);

    localparam int SettleW = $clog2(SettleCycles + 1);

    clearStateT         state;
    rowIndexT           sweepRow;                  // next row to be zeroed
    logic [SettleW-1:0] settleCount;

    rowIndexT writeRowIdx;
    colIndexT writeColIdx;
    rowIndexT readRowIdx;
    colIndexT readColIdx;

    // SSID is {row, col}
    assign {writeRowIdx, writeColIdx} = writeSsid;
    assign {readRowIdx, readColIdx}   = readSsid;

    // clear sequence after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= clearIdle;
            sweepRow    <= '0;
            settleCount <= '0;
        end else begin
            case (state)
                clearIdle: begin
                    state <= clearSweep;           // start the zero sweep
                end
                clearSweep: begin
                    sweepRow <= sweepRow + 1'b1;
                    if (sweepRow == rowIndexT'(NumRows - 1)) begin
                        state <= clearSettle;      // last row written this cycle
                    end
                end
                clearSettle: begin
                    settleCount <= settleCount + 1'b1;
                    if (settleCount == SettleW'(SettleCycles - 1)) begin
                        state <= clearDone;
                    end
                end
                default: begin
                    state <= clearDone;            // stay here until the next reset
                end
            endcase
        end
    end

    assign ready = (state == clearDone);           // never drops once cleared

    // write port: zeros during the sweep, merged rows otherwise
    always_comb begin
        if (state == clearSweep) begin
            memPort.writeEnable = 1'b1;
            memPort.writeAddr   = sweepRow;
            memPort.writeData   = '0;
        end else begin
            memPort.writeEnable = mergeValid;      // write back lands one edge after merge
            memPort.writeAddr   = mergeRow;
            memPort.writeData   = mergeData;
        end
    end

    // read address follows request priority, write then read then readRow
    always_comb begin
        if (write) begin
            memPort.readAddr = writeRowIdx;        // read half of the read-modify-write
        end else if (read) begin
            memPort.readAddr = readRowIdx;
        end else begin
            memPort.readAddr = readRowIndex;
        end
    end

    // tag marks the read sampled by memory at the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            tag.push <= 1'b0;
        end else begin
            tag.push <= ready && (write || read || readRow); // ignored until cleared
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tag.kind <= kindMerge;
            tag.row  <= writeRowIdx;
            tag.col  <= writeColIdx;
        end else if (read) begin
            tag.kind <= kindBit;
            tag.row  <= readRowIdx;
            tag.col  <= readColIdx;
        end else begin
            tag.kind <= kindRow;
            tag.row  <= readRowIndex;
            tag.col  <= '0;                        // no column for a row dump
        end
    end

endmodule

// ==== verilog/rowMemory.sv ====
`timescale 1ns/1ps

module rowMemory import hitMapPkg::*; #(
    parameter int ReadLatency = 2                  // data registers after the address register
) (
    input logic    clk,
    memPortIf.mem  port
);

    rowBitsT  storage [NumRows];                   // hit map rows
    rowIndexT addrReg;                             // sampled read address
    rowBitsT  dataPipe [ReadLatency];              // read data delay chain

    // write port, visible to any read whose address was sampled at this edge or later
    always_ff @(posedge clk) begin
        if (port.writeEnable) begin
            storage[port.writeAddr] <= port.writeData;
        end
    end

    // read port, address register then ReadLatency data stages
    always_ff @(posedge clk) begin
        addrReg     <= port.readAddr;              // sample the requested row
        dataPipe[0] <= storage[addrReg];           // array lookup lands here
        for (int i = 1; i < ReadLatency; i++) begin
            dataPipe[i] <= dataPipe[i-1];          // extra output stages
        end
    end

    assign port.readData = dataPipe[ReadLatency-1]; // valid ReadLatency edges after sampling

endmodule

// ==== common/readTagIf.sv ====
`timescale 1ns/1ps

interface readTagIf import hitMapPkg::*, hitCtrlPkg::*; ();

    logic     push;                                // a read was issued at this edge
    readKindT kind;                                // how the returned row is used
    rowIndexT row;                                 // row that was read
    colIndexT col;                                 // column of interest, unused for row dumps

    // request side
    modport source (
        output push,
        output kind,
        output row,
        output col
    );

    // read pipeline side
    modport sink (
        input push,
        input kind,
        input row,
        input col
    );

endinterface

// ==== common/memPortIf.sv ====
`timescale 1ns/1ps

interface memPortIf import hitMapPkg::*; ();

    logic     writeEnable;                         // write strobe, one row per cycle
    rowIndexT writeAddr;                           // row being written
    rowBitsT  writeData;                           // full row contents to store
    rowIndexT readAddr;                            // row sampled by the read port
    rowBitsT  readData;                            // delayed read result

    // controller owns both addresses and the write data
    modport ctrl (
        output writeEnable,
        output writeAddr,
        output writeData,
        output readAddr
    );

    modport mem (
        input  writeEnable,
        input  writeAddr,
        input  writeData,
        input  readAddr,
        output readData
    );

    // read result consumer
    modport sink (
        input readData
    );

endinterface

// ==== common/hitCtrlPkg.sv ====
package hitCtrlPkg;

    // clear sequence run once after every reset
    typedef enum logic [1:0] {
        clearIdle,                                 // first cycle out of reset
        clearSweep,                                // writing zeros row by row
        clearSettle,                               // wait after the last row
        clearDone                                  // normal operation, ready high
    } clearStateT;

    // what a read coming back from memory is used for
    typedef enum logic [1:0] {
        kindBit,                                   // single bit lookup of an SSID
        kindRow,                                   // whole row dump
        kindMerge                                  // first half of a hit set
    } readKindT;

endpackage

// ==== common/hitMapPkg.sv ====
package hitMapPkg;

    // hit map geometry, a row of column bits per memory word
    localparam int NumRows  = 32;                  // memory rows
    localparam int NumCols  = 16;                  // hit bits per row
    localparam int RowBitsW = 5;                   // row index width
    localparam int ColBitsW = 4;                   // column index width

    // the row index sits in the upper SSID bits, the column in the lower ones
    typedef logic [RowBitsW-1:0] rowIndexT;        // selects one memory row
    typedef logic [ColBitsW-1:0] colIndexT;        // selects one bit within a row

    typedef logic [RowBitsW+ColBitsW-1:0] ssidT;   // superstrip id as {row, col}

    typedef logic [NumCols-1:0] rowBitsT;          // one full row of hit flags

endpackage
